/* rtl/extMemPkg.sv */
`default_nettype none

package extMemPkg;

    localparam int DATA_BITS = 32;
    localparam int LEN_BITS = 8;
    localparam int EXT_ADDR_BITS = 30;
    localparam int BUF_ADDR_BITS = 6;
    localparam int BUF_DEPTH = 1 << BUF_ADDR_BITS;

    // Host space splits on the top address bit
    localparam int HOST_ADDR_BITS = 8;
    localparam int HOST_BUF_BIT = HOST_ADDR_BITS - 1;
    localparam int REG_IDX_BITS = HOST_ADDR_BITS - 1;

    localparam logic [REG_IDX_BITS-1:0] REG_EXT_ADDR = 7'd0;
    localparam logic [REG_IDX_BITS-1:0] REG_LOCAL_ADDR = 7'd1;
    localparam logic [REG_IDX_BITS-1:0] REG_LEN = 7'd2;
    localparam logic [REG_IDX_BITS-1:0] REG_CTRL = 7'd3;

    localparam int CTRL_GO_BIT = 0;
    localparam int CTRL_DIR_BIT = 1;
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_DONE_BIT = 1;
    localparam int STAT_DIR_BIT = 2;

    // Bus latency from command word to first data beat
    localparam int WAIT_BITS = 3;
    localparam logic [WAIT_BITS-1:0] WR_WAIT = 3'd2;
    localparam logic [WAIT_BITS-1:0] RD_WAIT = 3'd4;

    typedef struct packed {
        logic                     dir;
        logic [EXT_ADDR_BITS-1:0] extAddr;
        logic [BUF_ADDR_BITS-1:0] localAddr;
        logic [LEN_BITS-1:0]      len;
    } dmaCmd_t;

    typedef enum logic [1:0] {IDLE, LAUNCH, RUN, FINISH} engState_t;

endpackage

`default_nettype wire

/* rtl/extMemInterface.sv */
`timescale 1ns/1ps
`default_nettype none

module extMemInterface
    import extMemPkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     en,
    input  logic                     write,
    input  logic [LEN_BITS-1:0]      len,
    input  logic [EXT_ADDR_BITS-1:0] addr,
    output logic                     busy,

    output logic                     advance,
    input  logic [DATA_BITS-1:0]     wrData,
    output logic [DATA_BITS-1:0]     rdData,

    output logic                     extOen,
    output logic                     extEn,
    output logic [DATA_BITS-1:0]     extBusOut,
    input  logic [DATA_BITS-1:0]     extBusIn
);

    logic                 active;
    logic                 isWrite;
    logic [LEN_BITS-1:0]  lenCnt;
    logic [WAIT_BITS-1:0] waitCnt;

    assign busy = active;
    assign advance = active && (waitCnt == '0);
    assign rdData = (advance && !isWrite) ? extBusIn : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            extEn <= 1'b0;
            extOen <= 1'b1;
            waitCnt <= '0;
        end else begin
            // Enable covers the command cycle and every cycle while active
            extEn <= active || en;

            if (!active && en) begin
                active <= 1'b1;
                isWrite <= write;
                lenCnt <= len;
                waitCnt <= write ? WR_WAIT : RD_WAIT;
                extOen <= 1'b1;
                extBusOut <= {write, 1'b0, addr};
            end else if (active) begin
                if (waitCnt != '0) begin
                    waitCnt <= waitCnt - 1'b1;
                    // Turn the bus around one cycle ahead of read data
                    if (waitCnt == WAIT_BITS'(1)) begin
                        extOen <= isWrite;
                    end
                end else begin
                    if (isWrite) begin
                        extBusOut <= wrData;
                    end
                    if (lenCnt == LEN_BITS'(1)) begin
                        active <= 1'b0;
                        extOen <= 1'b1;
                    end
                    lenCnt <= lenCnt - 1'b1;
                end
            end
        end
    end

    // Zero length would run the down-counter through 256 beats
    assert property (@(posedge clk) disable iff (rst) en |-> len != '0)
        else $error("burst launched with zero length");

endmodule

`default_nettype wire

/* rtl/dmaRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module dmaRegs
    import extMemPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      hostWrite,
    input  logic [HOST_ADDR_BITS-1:0] hostAddr,
    input  logic [DATA_BITS-1:0]      hostWdata,
    output logic [DATA_BITS-1:0]      hostRdata,

    input  logic                      busy,
    input  logic                      done,
    output logic                      go,
    output dmaCmd_t                   cmd,

    output logic                      bufWe,
    output logic [BUF_ADDR_BITS-1:0]  bufAddr,
    output logic [DATA_BITS-1:0]      bufWdata,
    input  logic [DATA_BITS-1:0]      bufRdata
);

    logic                    running;
    logic                    doneFlag;
    logic                    bufSel;
    logic                    regWrite;
    logic [REG_IDX_BITS-1:0] regIdx;
    logic [DATA_BITS-1:0]    statusWord;

    assign bufSel = hostAddr[HOST_BUF_BIT];
    assign regIdx = hostAddr[REG_IDX_BITS-1:0];
    // Command registers are frozen from go until done
    assign regWrite = hostWrite && !bufSel && !running;

    assign bufWe = hostWrite && bufSel;
    assign bufAddr = hostAddr[BUF_ADDR_BITS-1:0];
    assign bufWdata = hostWdata;

    always_comb begin
        statusWord = '0;
        statusWord[STAT_BUSY_BIT] = running || busy;
        statusWord[STAT_DONE_BIT] = doneFlag;
        statusWord[STAT_DIR_BIT] = cmd.dir;
    end

    always_comb begin
        hostRdata = '0;
        if (bufSel) begin
            hostRdata = bufRdata;
        end else begin
            case (regIdx)
                REG_EXT_ADDR:   hostRdata = DATA_BITS'(cmd.extAddr);
                REG_LOCAL_ADDR: hostRdata = DATA_BITS'(cmd.localAddr);
                REG_LEN:        hostRdata = DATA_BITS'(cmd.len);
                REG_CTRL:       hostRdata = statusWord;
                default:        hostRdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd <= '0;
            go <= 1'b0;
            running <= 1'b0;
            doneFlag <= 1'b0;
        end else begin
            go <= 1'b0;
            if (done) begin
                running <= 1'b0;
                doneFlag <= 1'b1;
            end
            if (regWrite) begin
                case (regIdx)
                    REG_EXT_ADDR:   cmd.extAddr <= hostWdata[EXT_ADDR_BITS-1:0];
                    REG_LOCAL_ADDR: cmd.localAddr <= hostWdata[BUF_ADDR_BITS-1:0];
                    REG_LEN:        cmd.len <= hostWdata[LEN_BITS-1:0];
                    REG_CTRL: begin
                        cmd.dir <= hostWdata[CTRL_DIR_BIT];
                        if (hostWdata[CTRL_GO_BIT]) begin
                            go <= 1'b1;
                            running <= 1'b1;
                            doneFlag <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // The running flag must cover the bus interface's whole active window
    assert property (@(posedge clk) disable iff (rst) go |-> !busy)
        else $error("go raised while a burst is active");

endmodule

`default_nettype wire

/* rtl/dmaEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module dmaEngine
    import extMemPkg::*;
(
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     go,
    input  dmaCmd_t                  cmd,

    output logic                     memEn,
    output logic                     memWrite,
    output logic [LEN_BITS-1:0]      memLen,
    output logic [EXT_ADDR_BITS-1:0] memAddr,
    input  logic                     busy,
    input  logic                     advance,
    output logic [DATA_BITS-1:0]     wrData,
    input  logic [DATA_BITS-1:0]     rdData,

    output logic [BUF_ADDR_BITS-1:0] bufAddr,
    output logic                     bufWe,
    output logic [DATA_BITS-1:0]     bufWdata,
    input  logic [DATA_BITS-1:0]     bufRdata,

    output logic                     done
);

    engState_t                state;
    logic [BUF_ADDR_BITS-1:0] beatOffset;

    assign memEn = (state == LAUNCH);
    assign memWrite = cmd.dir;
    assign memLen = cmd.len;
    assign memAddr = cmd.extAddr;

    // Buffer address wraps at the buffer depth
    assign bufAddr = cmd.localAddr + beatOffset;
    assign wrData = bufRdata;
    assign bufWe = advance && !cmd.dir;
    assign bufWdata = rdData;

    assign done = (state == FINISH);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            beatOffset <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (go) begin
                        state <= LAUNCH;
                    end
                end
                LAUNCH: begin
                    beatOffset <= '0;
                    state <= RUN;
                end
                // Interface busy is already up in the first RUN cycle
                RUN: begin
                    if (advance) begin
                        beatOffset <= beatOffset + 1'b1;
                    end
                    if (!busy) begin
                        state <= FINISH;
                    end
                end
                FINISH: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) advance |-> state == RUN)
        else $error("data beat outside the RUN state");

endmodule

`default_nettype wire

/* rtl/localBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module localBuffer
    import extMemPkg::*;
(
    input  logic                     clk,

    input  logic                     weA,
    input  logic [BUF_ADDR_BITS-1:0] addrA,
    input  logic [DATA_BITS-1:0]     wdataA,
    output logic [DATA_BITS-1:0]     rdataA,

    input  logic                     weB,
    input  logic [BUF_ADDR_BITS-1:0] addrB,
    input  logic [DATA_BITS-1:0]     wdataB,
    output logic [DATA_BITS-1:0]     rdataB
);

    logic [DATA_BITS-1:0] mem [BUF_DEPTH];

    assign rdataA = mem[addrA];
    assign rdataB = mem[addrB];

    always_ff @(posedge clk) begin
        if (weA) begin
            mem[addrA] <= wdataA;
        end
        if (weB) begin
            mem[addrB] <= wdataB;
        end
    end

    // Host and engine must never collide on one word
    assert property (@(posedge clk) !(weA && weB && addrA == addrB))
        else $error("both buffer ports write the same address");

endmodule

`default_nettype wire

/* rtl/extMemSys.sv */
`timescale 1ns/1ps
`default_nettype none

module extMemSys
    import extMemPkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      hostWrite,
    input  logic [HOST_ADDR_BITS-1:0] hostAddr,
    input  logic [DATA_BITS-1:0]      hostWdata,
    output logic [DATA_BITS-1:0]      hostRdata,

    output logic                      extOen,
    output logic                      extEn,
    output logic [DATA_BITS-1:0]      extBusOut,
    input  logic [DATA_BITS-1:0]      extBusIn
);

    logic                     go;
    logic                     done;
    dmaCmd_t                  cmd;

    logic                     memEn;
    logic                     memWrite;
    logic [LEN_BITS-1:0]      memLen;
    logic [EXT_ADDR_BITS-1:0] memAddr;
    logic                     memBusy;
    logic                     advance;
    logic [DATA_BITS-1:0]     wrData;
    logic [DATA_BITS-1:0]     rdData;

    // Port A is the engine, port B the host
    logic                     engBufWe;
    logic [BUF_ADDR_BITS-1:0] engBufAddr;
    logic [DATA_BITS-1:0]     engBufWdata;
    logic [DATA_BITS-1:0]     engBufRdata;
    logic                     hostBufWe;
    logic [BUF_ADDR_BITS-1:0] hostBufAddr;
    logic [DATA_BITS-1:0]     hostBufWdata;
    logic [DATA_BITS-1:0]     hostBufRdata;

    dmaRegs regs (
        .clk(clk),
        .rst(rst),
        .hostWrite(hostWrite),
        .hostAddr(hostAddr),
        .hostWdata(hostWdata),
        .hostRdata(hostRdata),
        .busy(memBusy),
        .done(done),
        .go(go),
        .cmd(cmd),
        .bufWe(hostBufWe),
        .bufAddr(hostBufAddr),
        .bufWdata(hostBufWdata),
        .bufRdata(hostBufRdata)
    );

    dmaEngine engine (
        .clk(clk),
        .rst(rst),
        .go(go),
        .cmd(cmd),
        .memEn(memEn),
        .memWrite(memWrite),
        .memLen(memLen),
        .memAddr(memAddr),
        .busy(memBusy),
        .advance(advance),
        .wrData(wrData),
        .rdData(rdData),
        .bufAddr(engBufAddr),
        .bufWe(engBufWe),
        .bufWdata(engBufWdata),
        .bufRdata(engBufRdata),
        .done(done)
    );

    localBuffer buffer (
        .clk(clk),
        .weA(engBufWe),
        .addrA(engBufAddr),
        .wdataA(engBufWdata),
        .rdataA(engBufRdata),
        .weB(hostBufWe),
        .addrB(hostBufAddr),
        .wdataB(hostBufWdata),
        .rdataB(hostBufRdata)
    );

    extMemInterface memIf (
        .clk(clk),
        .rst(rst),
        .en(memEn),
        .write(memWrite),
        .len(memLen),
        .addr(memAddr),
        .busy(memBusy),
        .advance(advance),
        .wrData(wrData),
        .rdData(rdData),
        .extOen(extOen),
        .extEn(extEn),
        .extBusOut(extBusOut),
        .extBusIn(extBusIn)
    );

endmodule

`default_nettype wire

/* sim/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

endmodule

`default_nettype wire

/* sim/extMemDevice.sv */
`timescale 1ns/1ps
`default_nettype none

module extMemDevice
    import extMemPkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 extEn,
    input  logic                 extOen,
    input  logic [DATA_BITS-1:0] extBusOut,
    output logic [DATA_BITS-1:0] extBusIn,
    output logic                 protoErr
);

    logic [DATA_BITS-1:0]     mem [logic [EXT_ADDR_BITS-1:0]];
    logic                     inBurst = 1'b0;
    logic                     violation = 1'b0;
    logic                     isWrite;
    logic [EXT_ADDR_BITS-1:0] base;
    int                       cyc;
    int                       readEnd;

    function automatic logic [DATA_BITS-1:0] readWord(input logic [EXT_ADDR_BITS-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {a, 2'b01};
    endfunction

    task automatic flagViolation(input string what);
        $display("Bus protocol violation at time %0t: %s", $time, what);
        violation <= 1'b1;
    endtask

    assign protoErr = violation;
    // Word k goes out in burst cycle 4+k while the bus is turned around
    assign extBusIn = (inBurst && !isWrite && !extOen) ?
        readWord(base + EXT_ADDR_BITS'(cyc - 4)) : '0;

    always @(posedge clk) begin
        if (rst) begin
            inBurst <= 1'b0;
            cyc <= 0;
            readEnd <= 0;
        end else if (!inBurst) begin
            if (extEn) begin
                if (!extOen) flagViolation("output enable low during the command word");
                if (extBusOut[DATA_BITS-2]) flagViolation("reserved command bit is set");
                inBurst <= 1'b1;
                isWrite <= extBusOut[DATA_BITS-1];
                base <= extBusOut[EXT_ADDR_BITS-1:0];
                cyc <= 1;
                readEnd <= 0;
            end else if (!extOen) begin
                flagViolation("output enable low on an idle bus");
            end
        end else begin
            cyc <= cyc + 1;
            if (isWrite) begin
                if (!extOen) flagViolation("output enable low during a write burst");
                if (extEn && cyc >= 3) begin
                    mem[base + EXT_ADDR_BITS'(cyc - 3)] = extBusOut;
                end
                if (!extEn) begin
                    if (cyc < 4) flagViolation("write burst ended before its first beat");
                    inBurst <= 1'b0;
                end
            end else begin
                if (cyc < 4 && !extOen) flagViolation("output enable low before read data");
                if (cyc == 4 && extOen) flagViolation("output enable high at the first read beat");
                if (cyc > 4 && !extOen && readEnd != 0) begin
                    flagViolation("output enable low again after read data");
                end
                if (cyc > 4 && extOen && readEnd == 0) readEnd <= cyc;
                if (!extEn) begin
                    if (readEnd == 0 || cyc != readEnd + 1) begin
                        flagViolation("read burst ended outside its window");
                    end
                    inBurst <= 1'b0;
                end else if (readEnd != 0 && cyc > readEnd) begin
                    flagViolation("enable held past the read window");
                end
            end
        end
    end

endmodule

`default_nettype wire

/* sim/extMemSysTb.sv */
`timescale 1ns/1ps
`default_nettype none

module extMemSysTb
    import extMemPkg::*;
();

    localparam int NUM_BURSTS = 40;
    localparam int MAX_LEN = 80;
    localparam int TIMEOUT_CYCLES = NUM_BURSTS * (255 + 10) + 5000;
    localparam logic [31:0] RAND_SEED = 32'h74e3b621;
    // Window straddles the top of the external address space
    localparam logic [EXT_ADDR_BITS-1:0] EXT_WINDOW_BASE = 30'h3fff_ff80;

    logic                      clk;
    logic                      rst;
    logic                      hostWrite;
    logic [HOST_ADDR_BITS-1:0] hostAddr;
    logic [DATA_BITS-1:0]      hostWdata;
    logic [DATA_BITS-1:0]      hostRdata;
    logic                      extOen;
    logic                      extEn;
    logic [DATA_BITS-1:0]      extBusOut;
    logic [DATA_BITS-1:0]      extBusIn;
    logic                      protoErr;
    int                        cycleCount = 0;

    logic [DATA_BITS-1:0] bufModel [BUF_DEPTH];
    logic [DATA_BITS-1:0] extModel [logic [EXT_ADDR_BITS-1:0]];

    tbClock clkGen (.clk(clk));

    extMemSys dut (
        .clk(clk),
        .rst(rst),
        .hostWrite(hostWrite),
        .hostAddr(hostAddr),
        .hostWdata(hostWdata),
        .hostRdata(hostRdata),
        .extOen(extOen),
        .extEn(extEn),
        .extBusOut(extBusOut),
        .extBusIn(extBusIn)
    );

    extMemDevice extMem (
        .clk(clk),
        .rst(rst),
        .extEn(extEn),
        .extOen(extOen),
        .extBusOut(extBusOut),
        .extBusIn(extBusIn),
        .protoErr(protoErr)
    );

    task automatic abortRun();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s, got %h, expected %h", $time, what, actual, expected);
            abortRun();
        end
    endtask

    function automatic logic [HOST_ADDR_BITS-1:0] regAddr(input logic [REG_IDX_BITS-1:0] idx);
        return {1'b0, idx};
    endfunction

    function automatic logic [HOST_ADDR_BITS-1:0] bufHostAddr(input int idx);
        return {1'b1, 1'b0, BUF_ADDR_BITS'(idx)};
    endfunction

    task automatic hostWriteWord(input logic [HOST_ADDR_BITS-1:0] addr,
                                 input logic [DATA_BITS-1:0] data);
        @(posedge clk);
        hostWrite <= 1'b1;
        hostAddr <= addr;
        hostWdata <= data;
        @(posedge clk);
        hostWrite <= 1'b0;
    endtask

    task automatic hostReadWord(input logic [HOST_ADDR_BITS-1:0] addr,
                                output logic [DATA_BITS-1:0] data);
        @(posedge clk);
        hostWrite <= 1'b0;
        hostAddr <= addr;
        @(negedge clk);
        data = hostRdata;
    endtask

    task automatic checkBuffer();
        logic [DATA_BITS-1:0] value;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            hostReadWord(bufHostAddr(i), value);
            checkValue(value, bufModel[i], "buffer word readback");
        end
    endtask

    task automatic runBurst(input logic toExt);
        logic [EXT_ADDR_BITS-1:0] extAddr;
        logic [BUF_ADDR_BITS-1:0] localAddr;
        logic [EXT_ADDR_BITS-1:0] a;
        logic [BUF_ADDR_BITS-1:0] b;
        logic [DATA_BITS-1:0]     status;
        int                       len;
        bit                       strayGo;
        extAddr = EXT_WINDOW_BASE + EXT_ADDR_BITS'($urandom % 256);
        localAddr = BUF_ADDR_BITS'($urandom);
        len = 1 + ($urandom % MAX_LEN);
        strayGo = ($urandom % 2) != 0;
        // Model moves words in beat order, so long bursts overwrite wrapped entries
        for (int k = 0; k < len; k++) begin
            a = extAddr + EXT_ADDR_BITS'(k);
            b = localAddr + BUF_ADDR_BITS'(k);
            if (toExt) begin
                extModel[a] = bufModel[b];
            end else begin
                if (!extModel.exists(a)) begin
                    extModel[a] = $urandom;
                    extMem.mem[a] = extModel[a];
                end
                bufModel[b] = extModel[a];
            end
        end
        hostWriteWord(regAddr(REG_EXT_ADDR), 32'(extAddr));
        hostWriteWord(regAddr(REG_LOCAL_ADDR), 32'(localAddr));
        hostWriteWord(regAddr(REG_LEN), 32'(len));
        hostWriteWord(regAddr(REG_CTRL), {30'b0, toExt, 1'b1});
        hostReadWord(regAddr(REG_CTRL), status);
        checkValue(32'(status[STAT_BUSY_BIT]), 32'd1, "busy right after go");
        if (strayGo) begin
            hostWriteWord(regAddr(REG_CTRL), {30'b0, !toExt, 1'b1});
        end
        hostReadWord(regAddr(REG_CTRL), status);
        while (status[STAT_BUSY_BIT]) begin
            checkValue(32'(status[STAT_DONE_BIT]), 32'd0, "done while busy");
            hostReadWord(regAddr(REG_CTRL), status);
        end
        checkValue(32'(status[STAT_DONE_BIT]), 32'd1, "done after burst");
        checkValue(32'(status[STAT_DIR_BIT]), 32'(toExt), "dir readback after burst");
        hostReadWord(regAddr(REG_LEN), status);
        checkValue(status, 32'(len), "len register after burst");
        if (toExt) begin
            for (int k = 0; k < len; k++) begin
                a = extAddr + EXT_ADDR_BITS'(k);
                checkValue(32'(extMem.mem.exists(a)), 32'd1, "external word written");
                checkValue(extMem.mem[a], extModel[a], "external word after write burst");
            end
        end else begin
            checkBuffer();
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("The run timed out after %0d cycles without finishing", cycleCount);
            abortRun();
        end
    end

    always @(posedge protoErr) begin
        abortRun();
    end

    initial begin
        logic [DATA_BITS-1:0] value;
        logic [DATA_BITS-1:0] word;
        rst = 1'b1;
        hostWrite = 1'b0;
        hostAddr = '0;
        hostWdata = '0;
        void'($urandom(RAND_SEED));
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        checkValue(32'(extEn), 32'd0, "extEn after reset");
        checkValue(32'(extOen), 32'd1, "extOen after reset");
        hostReadWord(regAddr(REG_CTRL), value);
        checkValue(value & 32'h3, 32'd0, "busy and done after reset");

        repeat (8) begin
            word = $urandom;
            hostWriteWord(regAddr(REG_EXT_ADDR), word);
            hostReadWord(regAddr(REG_EXT_ADDR), value);
            checkValue(value, {2'b0, word[29:0]}, "ext address register");
            word = $urandom;
            hostWriteWord(regAddr(REG_LOCAL_ADDR), word);
            hostReadWord(regAddr(REG_LOCAL_ADDR), value);
            checkValue(value, {26'b0, word[5:0]}, "local address register");
            word = $urandom;
            hostWriteWord(regAddr(REG_LEN), word);
            hostReadWord(regAddr(REG_LEN), value);
            checkValue(value, {24'b0, word[7:0]}, "len register");
        end

        for (int i = 0; i < BUF_DEPTH; i++) begin
            bufModel[i] = $urandom;
            hostWriteWord(bufHostAddr(i), bufModel[i]);
        end
        checkBuffer();

        repeat (NUM_BURSTS) begin
            runBurst(($urandom % 2) != 0);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
rtl/extMemPkg.sv
rtl/extMemInterface.sv
rtl/dmaRegs.sv
rtl/dmaEngine.sv
rtl/localBuffer.sv
rtl/extMemSys.sv
sim/tbClock.sv
sim/extMemDevice.sv
sim/extMemSysTb.sv
